// File: hdl/video_pkg.sv
// Types for the video side of the capture path
// Pixel word, field filter setting and the word index inside a burst

package video_pkg;

	// --------------------
	// Pixel data
	// --------------------

	// Two RGB565 pixels packed into one word from the video source
	typedef logic [31:0] pixel_word_t;

	// --------------------
	// Frame detection
	// --------------------

	// Bit 0 selects a frame start on a field change from 1 to 0
	// Bit 1 selects a frame start on a field change from 0 to 1
	// A value of zero never starts a frame, so capture stays off
	typedef logic [1:0] field_filter_t;

	// --------------------
	// Burst gathering
	// --------------------

	// Position of a word within the eight gathered words of one burst
	typedef logic [2:0] word_idx_t;

	// Index of the eighth word, after which the burst goes to memory
	localparam word_idx_t LAST_WORD = 3'd7;

endpackage

// File: hdl/fml_pkg.sv
// Types for the memory bus side of the capture path
// Address width, data beat, beat index and the burst request struct

package fml_pkg;

	// Default byte address width of the memory bus
	localparam int FML_DEPTH = 27;

	// One burst is 32 bytes, so the five low address bits are always zero
	localparam int BURST_ADR_LSB = 5;

	// One 64-bit data beat on the write data bus
	typedef logic [63:0] fml_beat_t;

	// Beat position within a four-beat burst
	typedef logic [1:0] beat_idx_t;

	// Request toward the memory slave
	// The address holds steady together with the strobe until the ack
	typedef struct packed {
		logic [FML_DEPTH-1:0] adr;
		logic                 stb;
	} fml_burst_req_t;

endpackage

// File: hdl/capture_burst_mem.sv
// Burst staging memory for the capture DMA
// Eight 32-bit words go in one at a time and leave as four 64-bit beats

`timescale 1ns/1ps

module capture_burst_mem
	import video_pkg::*;
	import fml_pkg::*;
(
	input  logic        sys_clk,

	// Write port from the video side
	input  logic        we,
	input  word_idx_t   wa,
	input  pixel_word_t wd,

	// Read port toward the memory bus
	input  beat_idx_t   ra,
	output fml_beat_t   rd
);

	// Small enough to map onto distributed RAM
	pixel_word_t mem [0:7];

	// --------------------
	// Write side
	// --------------------

	always_ff @(posedge sys_clk) begin
		if (we)
			mem[wa] <= wd;
	end

	// --------------------
	// Read side
	// --------------------

	// A beat holds the even word in its low half and the odd word in its high half
	// The read is registered, so the index has to be presented one cycle early
	always_ff @(posedge sys_clk) begin
		rd <= {mem[{ra, 1'b1}], mem[{ra, 1'b0}]};
	end

endmodule

// File: hdl/capture_dma.sv
// Capture DMA engine
// Frame start detection, word gathering into the burst memory,
// burst address generation and the memory write FSM

`timescale 1ns/1ps

module capture_dma
	import video_pkg::*;
	import fml_pkg::*;
#(
	parameter int fml_depth = FML_DEPTH
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst,

	// Settings and pulses shared with the register block
	input  field_filter_t                     field_filter,
	input  logic [fml_depth-BURST_ADR_LSB-1:0] adr_base,
	input  logic                              last_burst,
	output logic                              start_of_frame,
	output logic                              next_burst,

	// Video source
	input  logic                              v_stb,
	output logic                              v_ack,
	input  logic                              v_field,
	input  pixel_word_t                       v_rgb565,

	// Memory bus where every strobe is a write
	output fml_burst_req_t                    fml_req,
	input  logic                              fml_ack,
	output fml_beat_t                         fml_do
);

	typedef enum logic [2:0] {
		wait_sof,
		gather,
		transfer,
		beat_1,
		beat_2,
		beat_3
	} dma_state_t;

	dma_state_t state;
	dma_state_t next_state;

	logic      accept;
	logic      prev_field;
	logic      data_en;
	logic      word_we;
	word_idx_t word_cnt;
	word_idx_t wa;
	beat_idx_t ra;
	logic      last_q;
	logic [fml_depth-BURST_ADR_LSB-1:0] adr_b;

	// --------------------
	// Frame start detection
	// --------------------

	// A word is taken whenever the source strobes and the engine is ready
	assign accept = v_stb & v_ack;

	// The field of every taken word is kept, including words that are thrown away
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			prev_field <= 1'b0;
		else if (accept)
			prev_field <= v_field;
	end

	// The word that carries the selected field change is the first word of the frame
	assign start_of_frame = accept &
		((field_filter[0] & prev_field & ~v_field) |
		 (field_filter[1] & ~prev_field & v_field));

	// --------------------
	// Word gathering
	// --------------------

	// A frame start always lands in word 0, even in the middle of a burst
	assign wa = start_of_frame ? '0 : word_cnt;
	assign word_we = accept & data_en;

	// The counter wraps to zero after the eighth word of each burst
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			word_cnt <= '0;
		else if (word_we)
			word_cnt <= wa + 1'b1;
	end

	capture_burst_mem burst_mem (
		.sys_clk (sys_clk),
		.we      (word_we),
		.wa      (wa),
		.wd      (v_rgb565),
		.ra      (ra),
		.rd      (fml_do)
	);

	// --------------------
	// Burst address
	// --------------------

	// Counts in 32-byte bursts, starting over at the base on each frame
	always_ff @(posedge sys_clk) begin
		if (start_of_frame)
			adr_b <= adr_base;
		else if (next_burst)
			adr_b <= adr_b + 1'b1;
	end

	assign fml_req = '{
		adr: FML_DEPTH'({adr_b, {BURST_ADR_LSB{1'b0}}}),
		stb: state == transfer
	};

	// Whether the burst being acked closes the frame
	// The register block still counts the previous bursts at the ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			last_q <= 1'b0;
		else if ((state == transfer) && fml_ack)
			last_q <= last_burst;
	end

	// --------------------
	// Burst write FSM
	// --------------------

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= wait_sof;
		else
			state <= next_state;
	end

	// The video side is only held off while a burst is on the memory bus
	assign v_ack = (state == wait_sof) || (state == gather);

	always_comb begin
		next_state = state;
		data_en = 1'b0;
		next_burst = 1'b0;
		ra = 2'd0;
		case (state)
			wait_sof: begin
				// Only the frame start word is kept, all others are dropped
				data_en = start_of_frame;
				if (start_of_frame)
					next_state = gather;
			end
			gather: begin
				data_en = 1'b1;
				if (accept && (wa == LAST_WORD))
					next_state = transfer;
			end
			transfer: begin
				// Beat 0 stays on the bus until the slave takes it
				if (fml_ack) begin
					ra = 2'd1;
					next_state = beat_1;
				end
			end
			beat_1: begin
				ra = 2'd2;
				next_burst = 1'b1;
				next_state = beat_2;
			end
			beat_2: begin
				ra = 2'd3;
				next_state = beat_3;
			end
			beat_3: begin
				if (last_q)
					next_state = wait_sof;
				else
					next_state = gather;
			end
			default: next_state = wait_sof;
		endcase
	end

endmodule

// File: hdl/capture_ctrl.sv
// Register block of the capture path
// Field filter, base address and bursts per frame registers,
// burst counter that flags the last burst, and the finished frame counter

`timescale 1ns/1ps

module capture_ctrl
	import video_pkg::*;
	import fml_pkg::*;
#(
	parameter int fml_depth = FML_DEPTH
) (
	input  logic                              sys_clk,
	input  logic                              sys_rst,

	// Register port
	input  logic                              csr_we,
	input  logic [1:0]                        csr_adr,
	input  logic [31:0]                       csr_di,
	output logic [31:0]                       csr_do,

	// Pulses from the DMA engine
	input  logic                              start_of_frame,
	input  logic                              next_burst,

	// Settings and status toward the DMA engine
	output field_filter_t                     field_filter,
	output logic [fml_depth-BURST_ADR_LSB-1:0] adr_base,
	output logic                              last_burst
);

	logic [fml_depth-BURST_ADR_LSB-1:0] bursts_per_frame;
	logic [fml_depth-BURST_ADR_LSB-1:0] bpf_last;
	logic [fml_depth-BURST_ADR_LSB-1:0] burst_cnt;
	logic [31:0] frame_cnt;

	// --------------------
	// Writable registers
	// --------------------

	// Register 3 is the frame count and ignores writes
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			field_filter <= '0;
			adr_base <= '0;
			bursts_per_frame <= '0;
		end else if (csr_we) begin
			case (csr_adr)
				2'd0: field_filter <= csr_di[1:0];
				2'd1: adr_base <= csr_di[fml_depth-1:BURST_ADR_LSB];
				2'd2: bursts_per_frame <= csr_di[fml_depth-BURST_ADR_LSB-1:0];
				default: ;
			endcase
		end
	end

	// Read data follows the address by one cycle
	always_ff @(posedge sys_clk) begin
		case (csr_adr)
			2'd0: csr_do <= 32'(field_filter);
			2'd1: csr_do <= 32'({adr_base, {BURST_ADR_LSB{1'b0}}});
			2'd2: csr_do <= 32'(bursts_per_frame);
			default: csr_do <= frame_cnt;
		endcase
	end

	// --------------------
	// Burst and frame counting
	// --------------------

	// Bursts already written in the current frame
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			burst_cnt <= '0;
		else if (start_of_frame)
			burst_cnt <= '0;
		else if (next_burst)
			burst_cnt <= burst_cnt + 1'b1;
	end

	// The burst in flight is the last one once all earlier ones are counted
	assign bpf_last = bursts_per_frame - 1'b1;
	assign last_burst = (burst_cnt == bpf_last);

	// A frame is finished when the last burst completes
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			frame_cnt <= '0;
		else if (next_burst && last_burst)
			frame_cnt <= frame_cnt + 1'b1;
	end

endmodule

// File: hdl/capture_top.sv
// Top level of the video capture path
// Register block and DMA engine, with the register port, the video port
// and the memory bus brought out

`timescale 1ns/1ps

module capture_top
	import video_pkg::*;
	import fml_pkg::*;
#(
	parameter int fml_depth = FML_DEPTH
) (
	input  logic           sys_clk,
	input  logic           sys_rst,

	// Register port
	input  logic           csr_we,
	input  logic [1:0]     csr_adr,
	input  logic [31:0]    csr_di,
	output logic [31:0]    csr_do,

	// Video source
	input  logic           v_stb,
	output logic           v_ack,
	input  logic           v_field,
	input  pixel_word_t    v_rgb565,

	// Memory bus
	output fml_burst_req_t fml_req,
	input  logic           fml_ack,
	output fml_beat_t      fml_do
);

	// Settings and handshake pulses between the two blocks
	field_filter_t field_filter;
	logic [fml_depth-BURST_ADR_LSB-1:0] adr_base;
	logic last_burst;
	logic start_of_frame;
	logic next_burst;

	capture_ctrl #(
		.fml_depth (fml_depth)
	) ctrl (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.csr_we         (csr_we),
		.csr_adr        (csr_adr),
		.csr_di         (csr_di),
		.csr_do         (csr_do),
		.start_of_frame (start_of_frame),
		.next_burst     (next_burst),
		.field_filter   (field_filter),
		.adr_base       (adr_base),
		.last_burst     (last_burst)
	);

	capture_dma #(
		.fml_depth (fml_depth)
	) dma (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.field_filter   (field_filter),
		.adr_base       (adr_base),
		.last_burst     (last_burst),
		.start_of_frame (start_of_frame),
		.next_burst     (next_burst),
		.v_stb          (v_stb),
		.v_ack          (v_ack),
		.v_field        (v_field),
		.v_rgb565       (v_rgb565),
		.fml_req        (fml_req),
		.fml_ack        (fml_ack),
		.fml_do         (fml_do)
	);

endmodule

// File: verification/capture_tb.sv
// Testbench for the video capture path
// Reads capture_patterns.hex, drives the video source and registers,
// models the memory slave and checks each burst and the frame count

`timescale 1ns/1ps

module capture_tb
	import video_pkg::*;
	import fml_pkg::*;
();

	logic           sys_clk;
	logic           sys_rst;
	logic           csr_we;
	logic [1:0]     csr_adr;
	logic [31:0]    csr_di;
	logic [31:0]    csr_do;
	logic           v_stb;
	logic           v_ack;
	logic           v_field;
	pixel_word_t    v_rgb565;
	fml_burst_req_t fml_req;
	logic           fml_ack;
	fml_beat_t      fml_do;

	// Raw pattern file and the expected bursts of the running test
	logic [31:0]          pat [0:255];
	logic [FML_DEPTH-1:0] exp_adr [0:15];
	fml_beat_t            exp_beat [0:63];
	string                cur_name;
	int unsigned          stall_limit;
	int unsigned          exp_bursts;
	int unsigned          bursts_seen;
	int unsigned          cycle_cnt;
	int unsigned          timeout_limit;

	capture_top #(
		.fml_depth (FML_DEPTH)
	) dut0 (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.csr_we   (csr_we),
		.csr_adr  (csr_adr),
		.csr_di   (csr_di),
		.csr_do   (csr_do),
		.v_stb    (v_stb),
		.v_ack    (v_ack),
		.v_field  (v_field),
		.v_rgb565 (v_rgb565),
		.fml_req  (fml_req),
		.fml_ack  (fml_ack),
		.fml_do   (fml_do)
	);

	always #5 sys_clk = ~sys_clk;

	// --------------------
	// Error reporting and checks
	// --------------------

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_beat(input string name, input fml_beat_t exp, input fml_beat_t act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s beat: expected %h, actual %h",
				name, exp, act));
	endtask

	task automatic check_adr(input string name, input logic [FML_DEPTH-1:0] exp,
			input logic [FML_DEPTH-1:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s address: expected %h, actual %h",
				name, exp, act));
	endtask

	task automatic check_count(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s frame count: expected %0d, actual %0d",
				name, exp, act));
	endtask

	// The run is cut off if the DUT stops making progress
	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= timeout_limit) begin
			$display("Timeout after %0d cycles in test %s, the DUT stopped", cycle_cnt,
				cur_name);
			$display("*** FAILED ***");
			$fatal(1, "Timeout");
		end
	end

	// --------------------
	// Memory slave model
	// --------------------

	// Called at the first falling edge that shows a strobe
	// Beat 0 is taken in the ack cycle and beats 1 to 3 on the three cycles after it
	task automatic serve_burst();
		int unsigned delay;
		int unsigned first;
		int unsigned k;
		logic [FML_DEPTH-1:0] adr;
		adr = fml_req.adr;
		if (bursts_seen >= exp_bursts)
			report_failure($sformatf("Unexpected memory request at %h in test %s",
				adr, cur_name));
		check_adr(cur_name, exp_adr[bursts_seen], adr);
		delay = $urandom_range(stall_limit, 0);
		repeat (delay) begin
			@(negedge sys_clk);
			if (fml_req.stb !== 1'b1 || fml_req.adr !== adr)
				report_failure($sformatf("Request changed before ack in test %s", cur_name));
		end
		@(posedge sys_clk);
		fml_ack <= 1'b1;
		@(negedge sys_clk);
		if (fml_req.stb !== 1'b1)
			report_failure($sformatf("Strobe dropped in the ack cycle in test %s", cur_name));
		first = bursts_seen * 4;
		check_beat(cur_name, exp_beat[first], fml_do);
		@(posedge sys_clk);
		fml_ack <= 1'b0;
		for (k = 1; k < 4; k++) begin
			@(negedge sys_clk);
			check_beat(cur_name, exp_beat[first + k], fml_do);
		end
		bursts_seen = bursts_seen + 1;
	endtask

	always begin
		@(negedge sys_clk);
		if (fml_req.stb === 1'b1)
			serve_burst();
	end

	// --------------------
	// Stimulus helpers
	// --------------------

	function automatic string test_name(input logic [31:0] idx);
		case (idx)
			0: return "filter1_two_frames";
			1: return "filter2_rising_edge";
			2: return "filter3_both_edges";
			3: return "filter0_disabled";
			default: return "unknown_test";
		endcase
	endfunction

	// Room for every word plus the worst stall and some slack per word
	function automatic int unsigned compute_timeout();
		int unsigned p;
		int unsigned t;
		int unsigned total_words;
		int unsigned max_stall;
		p = 1;
		total_words = 0;
		max_stall = 0;
		for (t = 0; t < pat[0]; t++) begin
			total_words = total_words + pat[p + 5];
			if (pat[p + 4] > max_stall)
				max_stall = pat[p + 4];
			p = p + 10 + pat[p + 5] + pat[p + 6] * 9;
		end
		return total_words * (1 + max_stall + 5) + 200;
	endfunction

	// Addresses come first, then the beats as low and high word pairs
	task automatic load_expected(input int unsigned p, input int unsigned nb);
		int unsigned k;
		for (k = 0; k < nb; k++)
			exp_adr[k] = pat[p + k][FML_DEPTH-1:0];
		for (k = 0; k < nb * 4; k++)
			exp_beat[k] = {pat[p + nb + 2 * k + 1], pat[p + nb + 2 * k]};
	endtask

	task automatic apply_reset();
		@(posedge sys_clk);
		sys_rst <= 1'b1;
		repeat (4) @(posedge sys_clk);
		sys_rst <= 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
		@(posedge sys_clk);
		csr_we <= 1'b1;
		csr_adr <= adr;
		csr_di <= data;
		@(posedge sys_clk);
		csr_we <= 1'b0;
	endtask

	// Read data shows one cycle after the address
	task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
		@(posedge sys_clk);
		csr_adr <= adr;
		@(posedge sys_clk);
		@(negedge sys_clk);
		data = csr_do;
	endtask

	// Entered right after a rising edge and left on the edge that takes the word
	task automatic send_word(input pixel_word_t word, input logic field);
		int unsigned gap;
		gap = $urandom_range(2, 0);
		if (gap != 0) begin
			v_stb <= 1'b0;
			repeat (gap) @(posedge sys_clk);
		end
		v_stb <= 1'b1;
		v_field <= field;
		v_rgb565 <= word;
		@(negedge sys_clk);
		while (v_ack !== 1'b1)
			@(negedge sys_clk);
		@(posedge sys_clk);
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		int unsigned ptr;
		int unsigned t;
		int unsigned i;
		int unsigned nw;
		int unsigned words_at;
		logic [63:0] mask;
		logic [31:0] count;
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_we = 1'b0;
		csr_adr = 2'd0;
		csr_di = 32'd0;
		v_stb = 1'b0;
		v_field = 1'b0;
		v_rgb565 = '0;
		fml_ack = 1'b0;
		cycle_cnt = 0;
		exp_bursts = 0;
		bursts_seen = 0;
		cur_name = "setup";
		void'($urandom(32'hc6687925));
		$readmemh("verification/capture_patterns.hex", pat);
		if ($isunknown(pat[0]) || pat[0] == 0)
			report_failure("Pattern file is missing or holds no tests");
		timeout_limit = compute_timeout();
		ptr = 1;
		for (t = 0; t < pat[0]; t++) begin
			cur_name = test_name(pat[ptr]);
			stall_limit = pat[ptr + 4];
			nw = pat[ptr + 5];
			exp_bursts = pat[ptr + 6];
			mask = {pat[ptr + 9], pat[ptr + 8]};
			words_at = ptr + 10;
			load_expected(words_at + nw, exp_bursts);
			bursts_seen = 0;
			apply_reset();
			@(negedge sys_clk);
			if (v_ack !== 1'b1 || fml_req.stb !== 1'b0)
				report_failure($sformatf("DUT is not idle after reset in test %s", cur_name));
			write_reg(2'd0, pat[ptr + 1]);
			write_reg(2'd1, pat[ptr + 2]);
			write_reg(2'd2, pat[ptr + 3]);
			for (i = 0; i < nw; i++)
				send_word(pat[words_at + i], mask[i]);
			v_stb <= 1'b0;
			while (bursts_seen < exp_bursts)
				@(posedge sys_clk);
			// A stray request would show up well inside this window
			repeat (16) @(posedge sys_clk);
			read_reg(2'd3, count);
			check_count(cur_name, pat[ptr + 7], count);
			ptr = words_at + nw + exp_bursts * 9;
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: verification/capture_patterns.hex
// Entry 0 is the test count. Per test: name, filter, base, bursts per frame, stall limit,
// words, bursts, frames, field mask low, field mask high, then the words,
// the burst addresses and the beats as low word / high word pairs
00000004
// filter 1, two frames of two bursts, field 1 words in between are dropped
00000000 00000001 00001234 00000002 00000003 00000024 00000004 00000002
000c0002 00000000
10000000 10000001 10000002 10000003 10000004 10000005 10000006 10000007
10000008 10000009 1000000a 1000000b 1000000c 1000000d 1000000e 1000000f
10000010 10000011 10000012 10000013 10000014 10000015 10000016 10000017
10000018 10000019 1000001a 1000001b 1000001c 1000001d 1000001e 1000001f
10000020 10000021 10000022 10000023
00001220 00001240 00001220 00001240
10000002 10000003 10000004 10000005 10000006 10000007 10000008 10000009
1000000a 1000000b 1000000c 1000000d 1000000e 1000000f 10000010 10000011
10000014 10000015 10000016 10000017 10000018 10000019 1000001a 1000001b
1000001c 1000001d 1000001e 1000001f 10000020 10000021 10000022 10000023
// filter 2, frames start on a rising field, one burst per frame, long stalls
00000001 00000002 00400010 00000001 00000006 00000012 00000002 00000002
0003fdfe 00000000
20000000 20000001 20000002 20000003 20000004 20000005 20000006 20000007
20000008 20000009 2000000a 2000000b 2000000c 2000000d 2000000e 2000000f
20000010 20000011
00400000 00400000
20000001 20000002 20000003 20000004 20000005 20000006 20000007 20000008
2000000a 2000000b 2000000c 2000000d 2000000e 2000000f 20000010 20000011
// filter 3, frames start on both field edges
00000002 00000003 0000abcf 00000001 00000002 00000011 00000002 00000002
000001fe 00000000
30000000 30000001 30000002 30000003 30000004 30000005 30000006 30000007
30000008 30000009 3000000a 3000000b 3000000c 3000000d 3000000e 3000000f
30000010
0000abc0 0000abc0
30000001 30000002 30000003 30000004 30000005 30000006 30000007 30000008
30000009 3000000a 3000000b 3000000c 3000000d 3000000e 3000000f 30000010
// filter 0, capture disabled, no request at all
00000003 00000000 00000100 00000001 00000001 0000000c 00000000 00000000
00000555 00000000
40000000 40000001 40000002 40000003 40000004 40000005 40000006 40000007
40000008 40000009 4000000a 4000000b

// File: project.f
hdl/video_pkg.sv
hdl/fml_pkg.sv
hdl/capture_burst_mem.sv
hdl/capture_dma.sv
hdl/capture_ctrl.sv
hdl/capture_top.sv
verification/capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the capture testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module capture_tb -f project.f -o capture_sim \
	&& ./obj_dir/capture_sim | tee sim.log \
	|| echo "Build or simulation stopped with an error"

grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
